//--- source/rbfu_pkg.sv
package rbfu_pkg;

    //////////////////////////////////////////////////
    // arithmetic constants
    //////////////////////////////////////////////////

    localparam int coef_w = 12;
    localparam int prod_w = 2 * coef_w;

    // modulus and Barrett constants, one bit wider than a coefficient
    localparam logic [coef_w:0] q_mod     = 13'd3329;
    localparam int              barrett_k = 24;
    localparam logic [coef_w:0] barrett_m = 13'd5039;

    // per item operation
    localparam logic op_ntt  = 1'b0;
    localparam logic op_intt = 1'b1;

    // registered stages from input to output
    localparam int pipe_depth = 4;

    //////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////

    typedef logic [coef_w-1:0] coef_t;

    typedef struct packed {
        coef_t a;
        coef_t b;
        coef_t w;
    } lane_in_t;

    typedef struct packed {
        coef_t d0;
        coef_t d1;
    } lane_out_t;

    typedef struct packed {
        logic           op;
        lane_in_t [1:0] lane;
    } bfly_req_t;

    typedef struct packed {
        lane_out_t [1:0] lane;
    } bfly_rsp_t;

endpackage

//--- source/mod_mul.sv
`timescale 1ns/100ps

module mod_mul (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            en,
    input  rbfu_pkg::coef_t x,
    input  rbfu_pkg::coef_t y,
    output rbfu_pkg::coef_t p
);

    // stage one product
    logic [rbfu_pkg::prod_w-1:0] prod_q;

    // barrett estimate, product times m before the shift
    logic [rbfu_pkg::prod_w+rbfu_pkg::coef_w:0] est_full;
    logic [rbfu_pkg::coef_w:0]                  quot;
    logic [rbfu_pkg::prod_w-1:0]                rem;
    logic [rbfu_pkg::coef_w:0]                  rem_lo;
    logic [rbfu_pkg::coef_w:0]                  red;

    //////////////////////////////////////////////////
    // stage one, plain 12 x 12 multiply
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod_q <= '0;
        end else if (en) begin
            prod_q <= x * y;
        end
    end

    //////////////////////////////////////////////////
    // stage two, reduction
    //////////////////////////////////////////////////

    always_comb begin
        est_full = prod_q * rbfu_pkg::barrett_m;
        // quotient estimate is at most one short
        quot     = est_full[rbfu_pkg::prod_w+rbfu_pkg::coef_w:rbfu_pkg::barrett_k];
        rem      = prod_q - quot * rbfu_pkg::q_mod;
        // remainder stays below 2q
        rem_lo   = rem[rbfu_pkg::coef_w:0];
        if (rem_lo >= rbfu_pkg::q_mod) begin
            red = rem_lo - rbfu_pkg::q_mod;
        end else begin
            red = rem_lo;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            p <= '0;
        end else if (en) begin
            p <= red[rbfu_pkg::coef_w-1:0];
        end
    end

endmodule

//--- source/rbfu_lane.sv
`timescale 1ns/100ps

module rbfu_lane (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                en,
    input  logic                op_entry,
    input  logic                op_post,
    input  rbfu_pkg::lane_in_t  lane_in,
    output rbfu_pkg::lane_out_t lane_out
);

    //////////////////////////////////////////////////
    // modular helpers, operands below q
    //////////////////////////////////////////////////

    function automatic rbfu_pkg::coef_t mod_add(input rbfu_pkg::coef_t x,
                                                input rbfu_pkg::coef_t y);
        logic [rbfu_pkg::coef_w:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= rbfu_pkg::q_mod) begin
            s = s - rbfu_pkg::q_mod;
        end
        return s[rbfu_pkg::coef_w-1:0];
    endfunction

    function automatic rbfu_pkg::coef_t mod_sub(input rbfu_pkg::coef_t x,
                                                input rbfu_pkg::coef_t y);
        logic [rbfu_pkg::coef_w:0] d;
        d = {1'b0, x} - {1'b0, y};
        // borrow wraps, adding q brings it back in range
        if (x < y) begin
            d = d + rbfu_pkg::q_mod;
        end
        return d[rbfu_pkg::coef_w-1:0];
    endfunction

    // x/2 mod q, odd values take +q first
    function automatic rbfu_pkg::coef_t mod_half(input rbfu_pkg::coef_t x);
        logic [rbfu_pkg::coef_w:0] s;
        if (x[0]) begin
            s = {1'b0, x} + rbfu_pkg::q_mod;
        end else begin
            s = {1'b0, x};
        end
        return s[rbfu_pkg::coef_w:1];
    endfunction

    rbfu_pkg::coef_t o_in;
    rbfu_pkg::coef_t e_in;
    rbfu_pkg::coef_t o_s1;
    rbfu_pkg::coef_t e_s1;
    rbfu_pkg::coef_t w_s1;
    rbfu_pkg::coef_t o_s2;
    rbfu_pkg::coef_t o_s3;
    rbfu_pkg::coef_t r_s3;
    rbfu_pkg::lane_out_t post;

    //////////////////////////////////////////////////
    // entry stage
    //////////////////////////////////////////////////

    // intt folds the gentleman-sande add/sub in front of the multiply
    always_comb begin
        if (op_entry == rbfu_pkg::op_intt) begin
            o_in = mod_add(lane_in.a, lane_in.b);
            e_in = mod_sub(lane_in.b, lane_in.a);
        end else begin
            o_in = lane_in.a;
            e_in = lane_in.b;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            o_s1 <= '0;
            e_s1 <= '0;
            w_s1 <= '0;
        end else if (en) begin
            o_s1 <= o_in;
            e_s1 <= e_in;
            w_s1 <= lane_in.w;
        end
    end

    //////////////////////////////////////////////////
    // multiply, o delayed alongside
    //////////////////////////////////////////////////

    mod_mul u_mod_mul (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (en),
        .x      (e_s1),
        .y      (w_s1),
        .p      (r_s3)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            o_s2 <= '0;
            o_s3 <= '0;
        end else if (en) begin
            o_s2 <= o_s1;
            o_s3 <= o_s2;
        end
    end

    //////////////////////////////////////////////////
    // output stage
    //////////////////////////////////////////////////

    always_comb begin
        if (op_post == rbfu_pkg::op_intt) begin
            post.d0 = mod_half(o_s3);
            post.d1 = mod_half(r_s3);
        end else begin
            post.d0 = mod_add(o_s3, r_s3);
            post.d1 = mod_sub(o_s3, r_s3);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane_out <= '0;
        end else if (en) begin
            lane_out <= post;
        end
    end

endmodule

//--- source/rbfu_pipe_ctrl.sv
`timescale 1ns/100ps

module rbfu_pipe_ctrl (
    input  logic clk,
    input  logic arst_n,
    input  logic in_valid,
    input  logic in_op,
    input  logic out_ready,
    output logic in_ready,
    output logic en,
    output logic op_post,
    output logic out_valid
);

    // one valid bit per registered stage
    logic [rbfu_pkg::pipe_depth-1:0] vld_q;

    // op is only needed up to the stage feeding the output register
    logic [rbfu_pkg::pipe_depth-2:0] op_q;

    //////////////////////////////////////////////////
    // stall and handshake
    //////////////////////////////////////////////////

    assign out_valid = vld_q[rbfu_pkg::pipe_depth-1];

    // whole pipe moves unless the output holds an unaccepted item
    assign en       = !out_valid || out_ready;
    assign in_ready = en;
    assign op_post  = op_q[rbfu_pkg::pipe_depth-2];

    //////////////////////////////////////////////////
    // valid and op shift registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
            op_q  <= '0;
        end else if (en) begin
            vld_q <= {vld_q[rbfu_pkg::pipe_depth-2:0], in_valid};
            op_q  <= {op_q[rbfu_pkg::pipe_depth-3:0], in_op};
        end
    end

endmodule

//--- source/rbfu_top.sv
`timescale 1ns/100ps

module rbfu_top (
    input  logic                clk,
    input  logic                arst_n,

    // request side
    input  logic                in_valid,
    output logic                in_ready,
    input  rbfu_pkg::bfly_req_t in_req,

    // response side
    output logic                out_valid,
    input  logic                out_ready,
    output rbfu_pkg::bfly_rsp_t out_rsp
);

    logic en;
    logic op_post;

    //////////////////////////////////////////////////
    // pipeline control
    //////////////////////////////////////////////////

    rbfu_pipe_ctrl u_pipe_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_op     (in_req.op),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .en        (en),
        .op_post   (op_post),
        .out_valid (out_valid)
    );

    //////////////////////////////////////////////////
    // butterfly lanes
    //////////////////////////////////////////////////

    // both lanes share the op and the stall enable
    for (genvar i = 0; i < 2; i++) begin : g_lane
        rbfu_lane u_lane (
            .clk      (clk),
            .arst_n   (arst_n),
            .en       (en),
            .op_entry (in_req.op),
            .op_post  (op_post),
            .lane_in  (in_req.lane[i]),
            .lane_out (out_rsp.lane[i])
        );
    end

endmodule

//--- bench/tb_rbfu.sv
`timescale 1ns/100ps

module tb_rbfu;

    localparam string trace_file = "bench/rbfu_trace.txt";

    // cycles from offering an item to seeing it on the output
    localparam int latency = 4;

    logic                clk;
    logic                arst_n;
    logic                in_valid;
    logic                in_ready;
    rbfu_pkg::bfly_req_t in_req;
    logic                out_valid;
    logic                out_ready;
    rbfu_pkg::bfly_rsp_t out_rsp;

    // trace contents and scoreboard
    rbfu_pkg::bfly_req_t req_q[$];
    rbfu_pkg::bfly_rsp_t rsp_q[$];
    rbfu_pkg::bfly_rsp_t exp_q[$];
    int                  acc_q[$];

    integer seed;
    int     data_errs;
    int     ctrl_errs;
    int     cycles;
    int     cycle_limit;
    int     sample;
    int     n_acc;
    int     n_out;

    rbfu_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run stopped after %0d cycles, items are stuck in the pipeline", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // every output handshake, expected or not
    always @(posedge clk) begin
        if (out_valid && out_ready) begin
            n_out++;
        end
    end

    //////////////////////////////////////////////////
    // trace loading
    //////////////////////////////////////////////////

    task automatic load_trace(output bit ok);
        int                  fd;
        int                  cnt;
        int                  v[11];
        string               line;
        rbfu_pkg::bfly_req_t req;
        rbfu_pkg::bfly_rsp_t rsp;
        ok = 1'b0;
        fd = $fopen(trace_file, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comment lines fail the first field and are skipped
                cnt = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d",
                              v[0], v[1], v[2], v[3], v[4], v[5],
                              v[6], v[7], v[8], v[9], v[10]);
                if (cnt == 11) begin
                    req.op         = v[0][0];
                    req.lane[0].a  = rbfu_pkg::coef_t'(v[1]);
                    req.lane[0].b  = rbfu_pkg::coef_t'(v[2]);
                    req.lane[0].w  = rbfu_pkg::coef_t'(v[3]);
                    req.lane[1].a  = rbfu_pkg::coef_t'(v[4]);
                    req.lane[1].b  = rbfu_pkg::coef_t'(v[5]);
                    req.lane[1].w  = rbfu_pkg::coef_t'(v[6]);
                    rsp.lane[0].d0 = rbfu_pkg::coef_t'(v[7]);
                    rsp.lane[0].d1 = rbfu_pkg::coef_t'(v[8]);
                    rsp.lane[1].d0 = rbfu_pkg::coef_t'(v[9]);
                    rsp.lane[1].d1 = rbfu_pkg::coef_t'(v[10]);
                    req_q.push_back(req);
                    rsp_q.push_back(rsp);
                end
            end
            $fclose(fd);
            ok = (req_q.size() > 0);
        end
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic check_coef(input string name, input rbfu_pkg::coef_t exp,
                              input rbfu_pkg::coef_t got);
        assert (got == exp) else begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, got);
            data_errs++;
        end
    endtask

    task automatic compare_rsp(input rbfu_pkg::bfly_rsp_t exp,
                               input rbfu_pkg::bfly_rsp_t got);
        check_coef("out_rsp.lane[0].d0", exp.lane[0].d0, got.lane[0].d0);
        check_coef("out_rsp.lane[0].d1", exp.lane[0].d1, got.lane[0].d1);
        check_coef("out_rsp.lane[1].d0", exp.lane[1].d0, got.lane[1].d0);
        check_coef("out_rsp.lane[1].d1", exp.lane[1].d1, got.lane[1].d1);
    endtask

    // empty pipe that can take an item
    task automatic check_idle();
        assert (out_valid == 1'b0) else begin
            $display("** Error at %0t: out_valid expected 0, got %0b", $time, out_valid);
            ctrl_errs++;
        end
        assert (in_ready == 1'b1) else begin
            $display("** Error at %0t: in_ready expected 1, got %0b", $time, in_ready);
            ctrl_errs++;
        end
    endtask

    //////////////////////////////////////////////////
    // one pass over the whole trace
    //////////////////////////////////////////////////

    task automatic run_pass(input bit random_timing);
        int                  sent;
        int                  acc;
        bit                  offering;
        bit                  fire_in;
        bit                  fire_out;
        bit                  stalled;
        rbfu_pkg::bfly_rsp_t held;
        sent     = 0;
        offering = 1'b0;
        stalled  = 1'b0;
        held     = '0;
        sample   = 0;
        while (sent < req_q.size() || exp_q.size() > 0) begin
            @(negedge clk);
            // an offer stays up until it is taken
            if (!offering && sent < req_q.size()) begin
                offering = random_timing ? (($random(seed) & 3) != 0) : 1'b1;
            end
            if (sent < req_q.size()) begin
                in_req = req_q[sent];
            end
            in_valid  = offering;
            out_ready = random_timing ? (($random(seed) & 1) != 0) : 1'b1;
            #1;

            if (stalled) begin
                assert (out_valid == 1'b1) else begin
                    $display("** Error at %0t: out_valid expected 1, got %0b",
                             $time, out_valid);
                    ctrl_errs++;
                end
                assert (out_rsp == held) else begin
                    $display("** Error at %0t: out_rsp expected %h, got %h",
                             $time, held, out_rsp);
                    data_errs++;
                end
            end

            fire_in  = in_valid && in_ready;
            fire_out = out_valid && out_ready;
            if (fire_out) begin
                assert (exp_q.size() != 0) else begin
                    $display("output handshake at %0t with no item in flight", $time);
                    ctrl_errs++;
                end
                if (exp_q.size() != 0) begin
                    compare_rsp(exp_q.pop_front(), out_rsp);
                    acc = acc_q.pop_front();
                    if (!random_timing) begin
                        assert (sample - acc == latency) else begin
                            $display("** Error at %0t: latency expected %0d, got %0d",
                                     $time, latency, sample - acc);
                            ctrl_errs++;
                        end
                    end
                end
            end
            if (fire_in) begin
                exp_q.push_back(rsp_q[sent]);
                acc_q.push_back(sample);
                sent++;
                n_acc++;
                offering = 1'b0;
            end
            stalled = out_valid && !out_ready;
            held    = out_rsp;
            sample++;
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        bit ok;
        clk         = 1'b0;
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        in_req      = '0;
        out_ready   = 1'b0;
        seed        = 18;
        data_errs   = 0;
        ctrl_errs   = 0;
        cycles      = 0;
        cycle_limit = 0;
        n_acc       = 0;
        n_out       = 0;

        load_trace(ok);
        if (!ok) begin
            $display("could not read any items from %s", trace_file);
            $display(">>> FAIL");
            $finish;
        end else begin
            cycle_limit = 10 * req_q.size() + 50;

            repeat (2) begin
                @(negedge clk);
                check_idle();
            end
            arst_n = 1'b1;
            #1;
            check_idle();

            // back to back with out_ready high and then with random gaps and stalls
            run_pass(1'b0);
            run_pass(1'b1);

            // nothing may come out once the scoreboard is empty
            repeat (6) begin
                @(negedge clk);
                in_valid  = 1'b0;
                out_ready = 1'b1;
                #1;
                assert (out_valid == 1'b0) else begin
                    $display("** Error at %0t: out_valid expected 0, got %0b",
                             $time, out_valid);
                    ctrl_errs++;
                end
            end
            assert (n_out == n_acc) else begin
                $display("accepted %0d items but %0d came out", n_acc, n_out);
                ctrl_errs++;
            end

            $display("errors: data %0d, control %0d", data_errs, ctrl_errs);
            if (data_errs == 0 && ctrl_errs == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

//--- bench/rbfu_trace.txt
# op(0 ntt, 1 intt)  lane0 a b w  lane1 a b w  expected lane0 d0 d1  lane1 d0 d1
# all values decimal, below q = 3329
0 0 0 0 1 1 1 0 0 2 0
0 3328 1 1 0 1 1 0 3327 1 3328
0 3328 3328 3328 100 2 3328 0 3327 98 102
0 17 1000 2 5 1500 3 2017 1346 1176 2163
0 1234 100 100 3000 40 50 1247 1221 1671 1000
0 2500 17 200 10 3328 2 2571 2429 8 12
0 3000 1664 2 1 1665 2 2999 3001 2 0
0 2000 1234 567 777 3000 3000 2588 1412 2490 2393
1 0 0 0 1 0 1 0 0 1665 1664
1 2 4 1 3 6 1 3 1 1669 1666
1 3328 3328 1 3328 1 5 3328 0 0 5
1 100 300 7 500 100 9 200 700 300 1529
1 1000 2000 3 3000 3000 2 1500 1500 3000 0
1 11 22 333 7 5 3328 1681 167 6 1
1 1234 2345 1000 50 3000 17 125 2886 1525 1772
1 3327 1 2 3 2 3 1664 3 1667 1663
0 5 6 7 3328 2 1664 47 3292 3327 0
1 5 6 7 3328 2 1664 1670 1668 1665 2496
0 400 500 600 2222 1111 3 790 10 2226 2218
1 400 500 600 2222 1111 3 450 39 2 3327
0 9 9 9 3000 329 1 90 3257 0 2671
1 9 9 9 3000 329 1 9 0 0 329
0 1 3328 3328 2048 2048 2048 2 0 1812 2284
1 1 3328 3328 2048 2048 2048 0 1 2048 0
0 3100 2900 1700 123 456 789 2851 20 375 3200
1 3100 2900 1700 123 456 789 3000 3108 1954 3202
0 1665 1664 1 0 3328 3328 0 1 1 3328
1 1665 1664 1 0 3328 3328 0 1664 1664 1665

//--- vlog.f
source/rbfu_pkg.sv
source/mod_mul.sv
source/rbfu_lane.sv
source/rbfu_pipe_ctrl.sv
source/rbfu_top.sv
bench/tb_rbfu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rbfu testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rbfu \
    -f vlog.f

./obj_dir/Vtb_rbfu | tee sim.log

if grep -qxF ">>> PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
